//--- Bender.yml
package:
  name: sprite_regs

sources:
  - files:
      - rtl/sprite_pkg.sv
      - rtl/sprite_table_if.sv
      - rtl/sprite_attr_bank.sv
      - rtl/sprite_coord_match.sv
      - rtl/sprite_regs_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_sprite_regs.sv

//--- rtl/sprite_attr_bank.sv
/*
 * Sprite attribute storage.
 * Write decode per entry and field, background register, valid bits,
 * table revision toggle and the one-cycle success pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module sprite_attr_bank #(
	parameter int NUM_SPRITES = 31
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr_en,
	input  logic [sprite_pkg::IDX_W-1:0]  reg_sel,
	input  sprite_pkg::field_t            field_sel,
	input  logic [sprite_pkg::DATA_W-1:0] wr_data,
	output logic                          success,
	sprite_table_if.bank                  tbl
);

	localparam logic [sprite_pkg::IDX_W-1:0] LAST_SEL = NUM_SPRITES[sprite_pkg::IDX_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// field slices of the write data
	////////////////////////////////////////////////////////////////////////////

	sprite_pkg::coord_t wr_offset;
	sprite_pkg::coord_t wr_y;
	sprite_pkg::coord_t wr_x;
	sprite_pkg::coord_t wr_back;

	assign wr_offset = wr_data[sprite_pkg::OFFSET_LSB +: sprite_pkg::COORD_W];
	assign wr_y      = wr_data[sprite_pkg::Y_LSB +: sprite_pkg::COORD_W];
	assign wr_x      = wr_data[sprite_pkg::X_LSB +: sprite_pkg::COORD_W];
	assign wr_back   = wr_data[sprite_pkg::BACK_LSB +: sprite_pkg::COORD_W];

	////////////////////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////////////////////

	logic                   sel_back;   // entry 0, background field
	logic                   sel_sprite; // entry 1..N, sprite field
	logic                   wr_accept;
	logic [NUM_SPRITES-1:0] entry_we;   // one-hot per sprite slot

	assign sel_back = (reg_sel == '0) && (field_sel == sprite_pkg::FIELD_BACK);

	assign sel_sprite = (reg_sel != '0)
		&& (reg_sel <= LAST_SEL)
		&& (field_sel != sprite_pkg::FIELD_BACK);

	assign wr_accept = wr_en && (sel_back || sel_sprite);

	for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_entry_we
		localparam int unsigned SEL_I = i + 1;
		localparam logic [sprite_pkg::IDX_W-1:0] SEL = SEL_I[sprite_pkg::IDX_W-1:0];

		assign entry_we[i] = wr_en && sel_sprite && (reg_sel == SEL);
	end

	////////////////////////////////////////////////////////////////////////////
	// entry storage
	////////////////////////////////////////////////////////////////////////////

	sprite_pkg::sprite_entry_t entries_q [NUM_SPRITES];

	// only the named field of the addressed slot changes
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (entry_we[i]) begin
				case (field_sel)
					sprite_pkg::FIELD_OFFSET: entries_q[i].offset <= wr_offset;
					sprite_pkg::FIELD_Y:      entries_q[i].y      <= wr_y;
					default:                  entries_q[i].x      <= wr_x; // FIELD_X
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control state and background
	////////////////////////////////////////////////////////////////////////////

	logic [NUM_SPRITES-1:0] valid_q;
	logic                   table_rev_q;
	sprite_pkg::coord_t     background_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q      <= '0;
			table_rev_q  <= 1'b0;
			background_q <= '0;
			success      <= 1'b0;
		end else begin
			valid_q <= valid_q | entry_we; // sticky until reset
			success <= wr_accept;          // one cycle after the write edge
			if (wr_accept) begin
				table_rev_q <= ~table_rev_q;
			end
			if (wr_en && sel_back) begin
				background_q <= wr_back;
			end
		end
	end

	assign tbl.entries    = entries_q;
	assign tbl.valid      = valid_q;
	assign tbl.table_rev  = table_rev_q;
	assign tbl.background = background_q;

	////////////////////////////////////////////////////////////////////////////
	// assertions
	////////////////////////////////////////////////////////////////////////////

	// a success pulse needs a write on the previous edge
	a_success_after_write : assert property (
		@(posedge clk) disable iff (!rst_n)
		success |-> $past(wr_en)
	);

	// sprite fields do not exist in entry 0
	a_entry0_sprite_rejected : assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr_en && (reg_sel == '0) && (field_sel != sprite_pkg::FIELD_BACK)) |=> !success
	);

endmodule

`default_nettype wire

//--- rtl/sprite_coord_match.sv
/*
 * Coordinate lookup against the sprite table.
 * Parallel compare, lowest-index priority pick and the registered
 * hit flag, offset and result pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module sprite_coord_match #(
	parameter int NUM_SPRITES = 31
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               lookup_en,
	input  sprite_pkg::coord_t check_x,
	input  sprite_pkg::coord_t check_y,
	sprite_table_if.matcher    tbl,
	output logic               result_valid,
	output logic               hit,
	output sprite_pkg::coord_t offset_out
);

	////////////////////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////////////////////

	logic [NUM_SPRITES-1:0] match;
	logic                   any_match;
	sprite_pkg::coord_t     match_offset;

	// empty slots never match
	for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_cmp
		assign match[i] = tbl.valid[i]
			&& (tbl.entries[i].x == check_x)
			&& (tbl.entries[i].y == check_y);
	end

	assign any_match = |match;

	// walk down so the lowest index wins
	always_comb begin
		match_offset = '0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (match[i]) begin
				match_offset = tbl.entries[i].offset;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			hit          <= 1'b0;
			offset_out   <= '0;
		end else begin
			result_valid <= lookup_en; // single-cycle pulse
			if (lookup_en) begin
				hit        <= any_match;
				offset_out <= match_offset; // zero on a miss
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// assertions
	////////////////////////////////////////////////////////////////////////////

	// one result per lookup, exactly one cycle later
	a_result_timing : assert property (
		@(posedge clk) disable iff (!rst_n)
		(lookup_en |=> result_valid) and (result_valid |-> $past(lookup_en))
	);

	a_miss_offset_zero : assert property (
		@(posedge clk) disable iff (!rst_n)
		(result_valid && !hit) |-> (offset_out == '0)
	);

	// valid bits only grow, and only with an accepted write in the bank
	a_valid_monotonic : assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |->
			((tbl.valid & $past(tbl.valid)) == $past(tbl.valid))
			&& ($stable(tbl.table_rev) -> $stable(tbl.valid))
	);

endmodule

`default_nettype wire

//--- rtl/sprite_pkg.sv
/*
 * Shared definitions for the sprite attribute register bank.
 * Field widths and bit positions in the write data, the field
 * opcode and the packed layout of one sprite entry.
 */
`default_nettype none

package sprite_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int COORD_W = 9;  // offset, x, y and background
	localparam int IDX_W   = 5;  // entry index on reg_sel
	localparam int DATA_W  = 32; // write data bus

	////////////////////////////////////////////////////////////////////////////
	// field positions inside wr_data
	////////////////////////////////////////////////////////////////////////////

	localparam int OFFSET_LSB = 0;
	localparam int Y_LSB      = 9;
	localparam int X_LSB      = 18;
	localparam int BACK_LSB   = 0;  // entry 0 only

	// field selected by a write
	typedef enum logic [1:0] {
		FIELD_OFFSET = 2'd0,
		FIELD_Y      = 2'd1,
		FIELD_X      = 2'd2,
		FIELD_BACK   = 2'd3
	} field_t;

	typedef logic [COORD_W-1:0] coord_t;

	// one sprite, offset in the top bits
	typedef struct packed {
		coord_t offset;
		coord_t y;
		coord_t x;
	} sprite_entry_t;

endpackage

`default_nettype wire

//--- rtl/sprite_regs_top.sv
/*
 * Top level of the sprite attribute register bank.
 * Plain ports, the table interface, storage bank and lookup matcher.
 */
`timescale 1ns/1ps
`default_nettype none

module sprite_regs_top #(
	parameter int NUM_SPRITES = 31 // 1 to 31
) (
	input  logic                          clk,
	input  logic                          rst_n,

	// write side
	input  logic                          wr_en,
	input  logic [sprite_pkg::IDX_W-1:0]  reg_sel,
	input  logic [1:0]                    field_sel,
	input  logic [sprite_pkg::DATA_W-1:0] wr_data,
	output logic                          success,

	// lookup side
	input  logic                          lookup_en,
	input  sprite_pkg::coord_t            check_x,
	input  sprite_pkg::coord_t            check_y,
	output logic                          result_valid,
	output logic                          hit,
	output sprite_pkg::coord_t            offset_out,

	output sprite_pkg::coord_t            background
);

	////////////////////////////////////////////////////////////////////////////
	// table between bank and matcher
	////////////////////////////////////////////////////////////////////////////

	sprite_table_if #(
		.NUM_SPRITES (NUM_SPRITES)
	) tbl ();

	sprite_pkg::field_t field_op;

	assign field_op = sprite_pkg::field_t'(field_sel); // raw bits to opcode

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	sprite_attr_bank #(
		.NUM_SPRITES (NUM_SPRITES)
	) i_sprite_attr_bank (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.reg_sel   (reg_sel),
		.field_sel (field_op),
		.wr_data   (wr_data),
		.success   (success),
		.tbl       (tbl.bank)
	);

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////

	sprite_coord_match #(
		.NUM_SPRITES (NUM_SPRITES)
	) i_sprite_coord_match (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup_en    (lookup_en),
		.check_x      (check_x),
		.check_y      (check_y),
		.tbl          (tbl.matcher),
		.result_valid (result_valid),
		.hit          (hit),
		.offset_out   (offset_out)
	);

	assign background = tbl.background; // entry 0 straight out

endmodule

`default_nettype wire

//--- rtl/sprite_table_if.sv
/*
 * Sprite table as seen by the lookup side.
 * Entries, valid bits, a revision toggle and the background colour.
 */
`timescale 1ns/1ps
`default_nettype none

interface sprite_table_if #(
	parameter int NUM_SPRITES = 31
);

	sprite_pkg::sprite_entry_t entries [NUM_SPRITES]; // slot i holds sprite i+1
	logic [NUM_SPRITES-1:0]    valid;                 // set on first accepted write
	logic                      table_rev;             // flips on each accepted write
	sprite_pkg::coord_t        background;            // entry 0

	modport bank (
		output entries,
		output valid,
		output table_rev,
		output background
	);

	modport matcher (
		input entries,
		input valid,
		input table_rev
	);

endinterface

`default_nettype wire

//--- sources.f
+incdir+include
rtl/sprite_pkg.sv
rtl/sprite_table_if.sv
rtl/sprite_attr_bank.sv
rtl/sprite_coord_match.sv
rtl/sprite_regs_top.sv
tests/tb_sprite_regs.sv

//--- include/sprite_tb_tasks.svh
/*
 * Testbench helpers for the sprite register bank.
 * Value compare, reference model of the write rule and the lookup,
 * single write and single lookup sequences.
 */
`ifndef SPRITE_TB_TASKS_SVH
`define SPRITE_TB_TASKS_SVH
`default_nettype none

	////////////////////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, want);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// entry 0 takes only the background, sprites take only their own fields
	function automatic logic write_accepted(input logic [4:0] sel, input logic [1:0] fld);
		if (sel == 5'd0) begin
			return fld == sprite_pkg::FIELD_BACK;
		end
		return (int'(sel) <= NUM_SPRITES) && (fld != sprite_pkg::FIELD_BACK);
	endfunction

	task automatic model_write(
		input logic [4:0]  sel,
		input logic [1:0]  fld,
		input logic [31:0] data
	);
		if (!write_accepted(sel, fld)) begin
			return;
		end
		case (fld)
			sprite_pkg::FIELD_BACK:   exp_back = data[sprite_pkg::BACK_LSB +: 9];
			sprite_pkg::FIELD_OFFSET: exp_off[sel] = data[sprite_pkg::OFFSET_LSB +: 9];
			sprite_pkg::FIELD_Y:      exp_y[sel] = data[sprite_pkg::Y_LSB +: 9];
			default:                  exp_x[sel] = data[sprite_pkg::X_LSB +: 9];
		endcase
		if (sel != 5'd0) begin
			exp_valid[sel] = 1'b1;
		end
	endtask

	// returns {hit, offset} of the lowest valid entry holding the pair
	function automatic logic [9:0] model_lookup(input logic [8:0] x, input logic [8:0] y);
		for (int i = 1; i <= NUM_SPRITES; i++) begin
			if (exp_valid[i] && (exp_x[i] == x) && (exp_y[i] == y)) begin
				return {1'b1, exp_off[i]};
			end
		end
		return '0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus sequences
	////////////////////////////////////////////////////////////////////////////

	task automatic write_field(
		input logic [4:0]  sel,
		input logic [1:0]  fld,
		input logic [31:0] data
	);
		logic ok;
		ok = write_accepted(sel, fld);
		@(posedge clk);
		wr_en     <= 1'b1;
		reg_sel   <= sel;
		field_sel <= fld;
		wr_data   <= data;
		@(posedge clk);
		wr_en <= 1'b0; // sampled on this edge
		model_write(sel, fld, data);
		@(negedge clk);
		check_eq(success, ok, $sformatf("success, entry %0d field %0d", sel, fld));
		check_eq(background, exp_back, "background after write");
		@(negedge clk);
		check_eq(success, 1'b0, "success pulse width");
	endtask

	task automatic lookup_pair(input logic [8:0] x, input logic [8:0] y);
		logic [9:0] want;
		want = model_lookup(x, y);
		@(posedge clk);
		lookup_en <= 1'b1;
		check_x   <= x;
		check_y   <= y;
		@(posedge clk);
		lookup_en <= 1'b0;
		@(negedge clk);
		check_eq(result_valid, 1'b1, "result_valid after lookup");
		check_eq(hit, want[9], $sformatf("hit for (%0d, %0d)", x, y));
		check_eq(offset_out, want[8:0], $sformatf("offset for (%0d, %0d)", x, y));
		@(negedge clk);
		check_eq(result_valid, 1'b0, "result pulse width");
		check_eq(hit, want[9], "hit held");
		check_eq(offset_out, want[8:0], "offset held");
	endtask

`default_nettype wire
`endif

//--- tests/tb_sprite_regs.sv
/*
 * Testbench for the sprite attribute register bank.
 * Clock, reset, watchdog, reference model state and the directed tests.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_regs;

	localparam int NUM_SPRITES  = 31;  // DUT default
	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_OPS      = 90;  // writes and lookups over all tests
	localparam int WDOG_CYCLES  = NUM_OPS * 4 + 200;

	logic                clk;
	logic                rst_n;
	logic                wr_en;
	logic [4:0]          reg_sel;
	logic [1:0]          field_sel;
	logic [31:0]         wr_data;
	logic                success;
	logic                lookup_en;
	sprite_pkg::coord_t  check_x;
	sprite_pkg::coord_t  check_y;
	logic                result_valid;
	logic                hit;
	sprite_pkg::coord_t  offset_out;
	sprite_pkg::coord_t  background;

	int errors = 0;
	int checks = 0;

	// expected table indexed like reg_sel
	sprite_pkg::coord_t exp_off [1:NUM_SPRITES];
	sprite_pkg::coord_t exp_x [1:NUM_SPRITES];
	sprite_pkg::coord_t exp_y [1:NUM_SPRITES];
	logic               exp_valid [1:NUM_SPRITES];
	sprite_pkg::coord_t exp_back;

	sprite_regs_top i_sprite_regs_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.reg_sel      (reg_sel),
		.field_sel    (field_sel),
		.wr_data      (wr_data),
		.success      (success),
		.lookup_en    (lookup_en),
		.check_x      (check_x),
		.check_y      (check_y),
		.result_valid (result_valid),
		.hit          (hit),
		.offset_out   (offset_out),
		.background   (background)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		check_eq(success, 1'b0, "success after reset");
		check_eq(result_valid, 1'b0, "result_valid after reset");
		check_eq(hit, 1'b0, "hit after reset");
		check_eq(background, '0, "background after reset");
		check_eq(offset_out, '0, "offset_out after reset");
		lookup_pair(9'd0, 9'd0); // empty table misses
	endtask

	task automatic exercise_field_writes();
		logic [4:0] ids [6] = '{5'd1, 5'd2, 5'd4, 5'd5, 5'd6, 5'd9};
		sprite_pkg::coord_t old_x;
		// every entry gets all three fields before any lookup
		foreach (ids[k]) begin
			write_field(ids[k], sprite_pkg::FIELD_OFFSET, $urandom());
			write_field(ids[k], sprite_pkg::FIELD_Y, $urandom());
			write_field(ids[k], sprite_pkg::FIELD_X, $urandom());
		end
		foreach (ids[k]) begin
			lookup_pair(exp_x[ids[k]], exp_y[ids[k]]);
		end
		write_field(5'd2, sprite_pkg::FIELD_OFFSET, $urandom()); // x, y stay
		lookup_pair(exp_x[2], exp_y[2]);
		old_x = exp_x[4];
		write_field(5'd4, sprite_pkg::FIELD_X, $urandom()); // offset, y stay
		lookup_pair(exp_x[4], exp_y[4]);
		lookup_pair(old_x, exp_y[4]);
	endtask

	task automatic probe_rejected_writes();
		sprite_pkg::coord_t back_before;
		back_before = exp_back;
		write_field(5'd0, sprite_pkg::FIELD_OFFSET, $urandom());
		lookup_pair(exp_x[5], exp_y[5]);
		write_field(5'd5, sprite_pkg::FIELD_BACK, $urandom());
		check_eq(background, back_before, "background after rejected write");
		lookup_pair(exp_x[5], exp_y[5]);
		if (NUM_SPRITES < 31) begin
			write_field(5'(NUM_SPRITES + 1), sprite_pkg::FIELD_OFFSET, $urandom());
			lookup_pair(exp_x[1], exp_y[1]);
		end
	endtask

	task automatic set_background();
		logic [31:0] d;
		repeat (2) begin
			d = $urandom();
			write_field(5'd0, sprite_pkg::FIELD_BACK, d);
			check_eq(background, d[8:0], "background takes wr_data[8:0]");
		end
	endtask

	task automatic check_priority_and_miss();
		sprite_pkg::coord_t px;
		sprite_pkg::coord_t py;
		sprite_pkg::coord_t off3;
		logic [31:0]        d;
		logic [9:0]         r;
		px   = sprite_pkg::coord_t'($urandom());
		py   = sprite_pkg::coord_t'($urandom());
		off3 = sprite_pkg::coord_t'($urandom());
		d = $urandom();
		d[sprite_pkg::OFFSET_LSB +: 9] = off3;
		write_field(5'd3, sprite_pkg::FIELD_OFFSET, d);
		d[sprite_pkg::OFFSET_LSB +: 9] = off3 ^ 9'h155; // differs from entry 3
		write_field(5'd7, sprite_pkg::FIELD_OFFSET, d);
		d = $urandom();
		d[sprite_pkg::Y_LSB +: 9] = py;
		d[sprite_pkg::X_LSB +: 9] = px;
		write_field(5'd7, sprite_pkg::FIELD_Y, d);
		write_field(5'd7, sprite_pkg::FIELD_X, d);
		write_field(5'd3, sprite_pkg::FIELD_Y, d);
		write_field(5'd3, sprite_pkg::FIELD_X, d);
		lookup_pair(px, py);
		check_eq(offset_out, off3, "entry 3 wins over entry 7");
		// find a pair no valid entry holds
		do begin
			px = sprite_pkg::coord_t'($urandom());
			py = sprite_pkg::coord_t'($urandom());
			r  = model_lookup(px, py);
		end while (r[9]);
		lookup_pair(px, py);
		check_eq(hit, 1'b0, "miss clears hit");
		check_eq(offset_out, '0, "miss gives zero offset");
	endtask

	task automatic stream_lookups();
		sprite_pkg::coord_t lx [32];
		sprite_pkg::coord_t ly [32];
		logic [9:0]         want;
		logic [31:0]        d;
		int                 vids [$];
		int                 e;
		for (int i = 1; i <= NUM_SPRITES; i++) begin
			if (exp_valid[i]) begin
				vids.push_back(i);
			end
		end
		// even slots hit a stored pair, odd slots are random
		foreach (lx[k]) begin
			e = vids[$urandom_range(vids.size() - 1, 0)];
			lx[k] = (k % 2 == 0) ? exp_x[e] : sprite_pkg::coord_t'($urandom());
			ly[k] = (k % 2 == 0) ? exp_y[e] : sprite_pkg::coord_t'($urandom());
		end
		@(posedge clk);
		lookup_en <= 1'b1;
		check_x   <= lx[0];
		check_y   <= ly[0];
		want = model_lookup(lx[0], ly[0]);
		for (int k = 1; k <= 32; k++) begin
			@(posedge clk);
			if (k < 32) begin
				check_x <= lx[k];
				check_y <= ly[k];
			end else begin
				lookup_en <= 1'b0;
			end
			@(negedge clk);
			check_eq(result_valid, 1'b1, "streamed result_valid");
			check_eq(hit, want[9], $sformatf("streamed hit %0d", k - 1));
			check_eq(offset_out, want[8:0], $sformatf("streamed offset %0d", k - 1));
			if (k < 32) begin
				want = model_lookup(lx[k], ly[k]);
			end
		end
		// lookup sees the old offset when a write shares its edge
		d    = $urandom();
		d[sprite_pkg::OFFSET_LSB +: 9] = ~exp_off[2]; // never the stored offset
		want = model_lookup(exp_x[2], exp_y[2]);
		@(posedge clk);
		lookup_en <= 1'b1;
		check_x   <= exp_x[2];
		check_y   <= exp_y[2];
		wr_en     <= 1'b1;
		reg_sel   <= 5'd2;
		field_sel <= sprite_pkg::FIELD_OFFSET;
		wr_data   <= d;
		@(posedge clk);
		lookup_en <= 1'b0;
		wr_en     <= 1'b0;
		model_write(5'd2, sprite_pkg::FIELD_OFFSET, d);
		@(negedge clk);
		check_eq(success, 1'b1, "success with concurrent lookup");
		check_eq(result_valid, 1'b1, "result_valid with concurrent write");
		check_eq(hit, want[9], "hit with concurrent write");
		check_eq(offset_out, want[8:0], "old offset with concurrent write");
		lookup_pair(exp_x[2], exp_y[2]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(33));
		rst_n     = 1'b0;
		wr_en     = 1'b0;
		reg_sel   = '0;
		field_sel = '0;
		wr_data   = '0;
		lookup_en = 1'b0;
		check_x   = '0;
		check_y   = '0;
		exp_back  = '0;
		for (int i = 1; i <= NUM_SPRITES; i++) begin
			exp_valid[i] = 1'b0;
			exp_off[i]   = '0;
			exp_x[i]     = '0;
			exp_y[i]     = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_state();
		exercise_field_writes();
		probe_rejected_writes();
		set_background();
		check_priority_and_miss();
		stream_lookups();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	`include "sprite_tb_tasks.svh"

endmodule

`default_nettype wire
